/* Bender.yml */
package:
  name: acs

sources:
  - design/acsPkg.sv
  - design/rotBranchIf.sv
  - design/branchMetricIf.sv
  - design/branchRotator.sv
  - design/metricAdder.sv
  - design/survivorSelect.sv
  - design/acsTop.sv
  - target: test
    files:
      - dv/acsTb.sv

/* design/acsPkg.sv */
package acsPkg;

   // sample and metric widths used across the ACS datapath
   localparam int MF_BITS      = 10;  // matched-filter sample width
   localparam int ROT_BITS     = 8;   // rotator works on the top bits of each MF sample
   localparam int ACS_BITS     = 10;  // accumulated metric width
   localparam int NUM_BRANCHES = 4;   // trellis branches per symbol
   localparam int ANGLE_BITS   = 5;   // 32 phase steps per full turn
   localparam int TRIG_BITS    = 6;   // trig table is scaled by 2**TRIG_BITS

   // amount taken off the best metric when the loop asks for normalization
   localparam int NORM_OFFSET = 128;

   typedef logic signed [MF_BITS-1:0]  mfSample_t;
   typedef logic signed [ROT_BITS-1:0] rotSample_t;
   typedef logic signed [ACS_BITS-1:0] metric_t;
   typedef logic [1:0]                 branchIdx_t;
   typedef logic [ANGLE_BITS-1:0]      angle_t;
   typedef logic [4:0]                 tilt_t;

   // round(64 * sin(2*pi*k/32)), one entry per angle step
   // cosine is read eight steps further on, which is a quarter turn
   localparam logic signed [TRIG_BITS+1:0] sineTable [1 << ANGLE_BITS] = '{
        0,  12,  24,  36,  45,  53,  59,  63,
       64,  63,  59,  53,  45,  36,  24,  12,
        0, -12, -24, -36, -45, -53, -59, -63,
      -64, -63, -59, -53, -45, -36, -24, -12
   };

endpackage

/* design/acsTop.sv */
`timescale 1ns/100ps

module acsTop import acsPkg::*; #(
   parameter int ROT45 [NUM_BRANCHES] = '{0, 1, 2, 3},
   parameter int ROT54 [NUM_BRANCHES] = '{0, 3, 6, 9}
) (
   input  logic       clk,
   input  logic       reset,
   input  logic       symEn,
   input  logic       symEnEven,
   input  tilt_t      tilt,
   input  mfSample_t  mfI45 [NUM_BRANCHES],
   input  mfSample_t  mfQ45 [NUM_BRANCHES],
   input  mfSample_t  mfI54 [NUM_BRANCHES],
   input  mfSample_t  mfQ54 [NUM_BRANCHES],
   input  metric_t    accMet45 [NUM_BRANCHES],  // must hold from symEn until branch 0 lands
   input  metric_t    accMet54 [NUM_BRANCHES],
   input  logic       normalizeIn,
   output branchIdx_t selOut,
   output rotSample_t iOut,
   output rotSample_t qOut,
   output metric_t    accMetOut,
   output logic       normalizeOut,
   output logic       symEnOut                  // six edges after symEn
);

   rotBranchIf    rotBus ();     // serial rotated branches
   branchMetricIf metricBus ();  // parallel sums per symbol

   // stage 1, rotate each branch by tilt and its phase offset
   branchRotator #(
      .ROT45 (ROT45),
      .ROT54 (ROT54)
   ) rotStage (
      .clk       (clk),
      .reset     (reset),
      .symEn     (symEn),
      .symEnEven (symEnEven),
      .tilt      (tilt),
      .mfI45     (mfI45),
      .mfQ45     (mfQ45),
      .mfI54     (mfI54),
      .mfQ54     (mfQ54),
      .out       (rotBus)
   );

   // stage 2, add rotated I to the accumulated metrics
   metricAdder addStage (
      .clk      (clk),
      .reset    (reset),
      .accMet45 (accMet45),
      .accMet54 (accMet54),
      .in       (rotBus),
      .out      (metricBus)
   );

   // stage 3, compare and select the survivor
   survivorSelect selStage (
      .clk          (clk),
      .reset        (reset),
      .in           (metricBus),
      .normalizeIn  (normalizeIn),
      .selOut       (selOut),
      .iOut         (iOut),
      .qOut         (qOut),
      .accMetOut    (accMetOut),
      .normalizeOut (normalizeOut),
      .symEnOut     (symEnOut)
   );

endmodule

/* design/branchMetricIf.sv */
`timescale 1ns/100ps

// all four candidate metrics of one symbol, presented in parallel
interface branchMetricIf import acsPkg::*; ();

   logic       valid;               // one strobe per symbol
   metric_t    sum  [NUM_BRANCHES]; // accumulated metric plus rotated I, per branch
   rotSample_t rotI [NUM_BRANCHES]; // rotated pair that produced each sum
   rotSample_t rotQ [NUM_BRANCHES];

   // adder side drives the whole bundle
   modport src (
      output valid, sum, rotI, rotQ
   );

   // selector side
   modport dst (
      input valid, sum, rotI, rotQ
   );

endinterface

/* design/branchRotator.sv */
`timescale 1ns/100ps

module branchRotator import acsPkg::*; #(
   parameter int ROT45 [NUM_BRANCHES] = '{0, 1, 2, 3},  // phase offsets of the 45 set
   parameter int ROT54 [NUM_BRANCHES] = '{0, 3, 6, 9}   // phase offsets of the 54 set
) (
   input  logic      clk,
   input  logic      reset,
   input  logic      symEn,      // symbol strobe, inputs are sampled on this edge
   input  logic      symEnEven,  // high selects the 54 set for this symbol
   input  tilt_t     tilt,
   input  mfSample_t mfI45 [NUM_BRANCHES],
   input  mfSample_t mfQ45 [NUM_BRANCHES],
   input  mfSample_t mfI54 [NUM_BRANCHES],
   input  mfSample_t mfQ54 [NUM_BRANCHES],
   rotBranchIf.src   out
);

   // matched-filter samples held for the four rotator passes
   mfSample_t capI45 [NUM_BRANCHES];
   mfSample_t capQ45 [NUM_BRANCHES];
   mfSample_t capI54 [NUM_BRANCHES];
   mfSample_t capQ54 [NUM_BRANCHES];
   logic      capEven;
   tilt_t     capTilt;

   branchIdx_t branchCnt;  // branch being rotated this cycle
   logic       busy;       // high while branches of a captured symbol remain

   mfSample_t  selI, selQ;
   int         offset;
   angle_t     angle;
   rotSample_t inI, inQ;
   logic signed [TRIG_BITS+1:0]         sinVal, cosVal;
   logic signed [ROT_BITS+TRIG_BITS+2:0] prodI, prodQ;  // wide enough for two full products

   // sample everything on the symbol strobe, the MF outputs move on right after
   always_ff @(posedge clk) begin
      if (symEn) begin
         capI45  <= mfI45;
         capQ45  <= mfQ45;
         capI54  <= mfI54;
         capQ54  <= mfQ54;
         capEven <= symEnEven;
         capTilt <= tilt;
      end
   end

   // branch sequencer, one branch per clock after the strobe
   always_ff @(posedge clk) begin
      if (reset) begin
         busy      <= 1'b0;
         branchCnt <= '0;
         out.valid <= 1'b0;
      end else begin
         out.valid <= busy;  // the branch counted this cycle is registered on the bus
         if (symEn) begin
            busy      <= 1'b1;  // a new strobe restarts the sequence at branch 0
            branchCnt <= '0;
         end else if (busy) begin
            branchCnt <= branchCnt + 1'b1;
            if (branchCnt == NUM_BRANCHES - 1)
               busy <= 1'b0;  // last branch leaves this cycle
         end
      end
   end

   always_comb begin
      // pick the set named by the captured even flag
      selI   = capEven ? capI54[branchCnt] : capI45[branchCnt];
      selQ   = capEven ? capQ54[branchCnt] : capQ45[branchCnt];
      offset = capEven ? ROT54[branchCnt] : ROT45[branchCnt];

      // negative tilt plus twice the branch offset, wrapped to one turn
      angle = angle_t'((1 << ANGLE_BITS) - (int'(capTilt) + 2 * offset));

      // the rotator only sees the upper bits of each MF sample
      inI = selI[MF_BITS-1 -: ROT_BITS];
      inQ = selQ[MF_BITS-1 -: ROT_BITS];

      sinVal = sineTable[angle];
      cosVal = sineTable[angle_t'(angle + (1 << (ANGLE_BITS - 2)))];  // quarter turn ahead

      // complex multiply by exp(j*angle)
      prodI = inI * cosVal - inQ * sinVal;
      prodQ = inI * sinVal + inQ * cosVal;
   end

   // drop the trig scaling and wrap back to sample width
   always_ff @(posedge clk) begin
      out.branchIdx <= branchCnt;
      out.even      <= capEven;
      out.i         <= rotSample_t'(prodI >>> TRIG_BITS);
      out.q         <= rotSample_t'(prodQ >>> TRIG_BITS);
   end

endmodule

/* design/metricAdder.sv */
`timescale 1ns/100ps

module metricAdder import acsPkg::*; (
   input  logic      clk,
   input  logic      reset,
   input  metric_t   accMet45 [NUM_BRANCHES],  // accumulated metrics of the 45 set
   input  metric_t   accMet54 [NUM_BRANCHES],  // accumulated metrics of the 54 set
   rotBranchIf.dst   in,
   branchMetricIf.src out
);

   metric_t    metLatched [NUM_BRANCHES];  // metric set picked for the symbol in flight
   rotSample_t iSlot [NUM_BRANCHES-1];     // branches 0..2 wait here for branch 3
   rotSample_t qSlot [NUM_BRANCHES-1];

   rotSample_t iAll [NUM_BRANCHES];
   rotSample_t qAll [NUM_BRANCHES];
   metric_t    sumNext [NUM_BRANCHES];
   metric_t    iExt;

   logic firstBranch, lastBranch;

   assign firstBranch = in.valid && (in.branchIdx == '0);
   assign lastBranch  = in.valid && (in.branchIdx == NUM_BRANCHES - 1);

   // grab the metric set when branch 0 shows up, the even flag rides along with it
   always_ff @(posedge clk) begin
      if (firstBranch) begin
         for (int k = 0; k < NUM_BRANCHES; k++) begin
            metLatched[k] <= in.even ? accMet54[k] : accMet45[k];
         end
      end
   end

   // serial to parallel, branch 3 is never stored and goes straight to the adders
   always_ff @(posedge clk) begin
      if (in.valid && (in.branchIdx != NUM_BRANCHES - 1)) begin
         iSlot[in.branchIdx] <= in.i;
         qSlot[in.branchIdx] <= in.q;
      end
   end

   always_comb begin
      iExt = '0;
      for (int k = 0; k < NUM_BRANCHES; k++) begin
         iAll[k] = (k == NUM_BRANCHES - 1) ? in.i : iSlot[k];
         qAll[k] = (k == NUM_BRANCHES - 1) ? in.q : qSlot[k];
         iExt    = iAll[k];                  // signed assignment sign-extends
         sumNext[k] = metLatched[k] + iExt;  // two's complement wrap at ACS_BITS
      end
   end

   // one strobe per symbol, raised the cycle after branch 3 is seen
   always_ff @(posedge clk) begin
      if (reset)
         out.valid <= 1'b0;
      else
         out.valid <= lastBranch;
   end

   always_ff @(posedge clk) begin
      if (lastBranch) begin
         out.sum  <= sumNext;
         out.rotI <= iAll;
         out.rotQ <= qAll;
      end
   end

endmodule

/* design/rotBranchIf.sv */
`timescale 1ns/100ps

// one rotated branch per cycle, branches 0..3 of a symbol on consecutive cycles
interface rotBranchIf import acsPkg::*; ();

   logic       valid;      // single-cycle strobe per branch
   branchIdx_t branchIdx;  // which branch is on the bus this cycle
   logic       even;       // symEnEven captured with this symbol
   rotSample_t i;          // rotated in-phase sample
   rotSample_t q;          // rotated quadrature sample

   // the rotator drives everything
   modport src (
      output valid, branchIdx, even, i, q
   );

   // the metric adder only listens
   modport dst (
      input valid, branchIdx, even, i, q
   );

endinterface

/* design/survivorSelect.sv */
`timescale 1ns/100ps

module survivorSelect import acsPkg::*; (
   input  logic          clk,
   input  logic          reset,
   branchMetricIf.dst    in,
   input  logic          normalizeIn,   // loop asks to pull the metric down this symbol
   output branchIdx_t    selOut,        // surviving branch
   output rotSample_t    iOut,
   output rotSample_t    qOut,
   output metric_t       accMetOut,
   output logic          normalizeOut,  // best metric is getting close to overflow
   output logic          symEnOut
);

   branchIdx_t winIdx;
   metric_t    bestMetric;
   metric_t    normDiff;

   // signed four-way max, strict compare so a tie keeps the lower index
   always_comb begin
      winIdx = '0;
      for (int k = 1; k < NUM_BRANCHES; k++) begin
         if (in.sum[k] > in.sum[winIdx])
            winIdx = branchIdx_t'(k);
      end
   end

   // survivor registers, everything moves on the same edge
   always_ff @(posedge clk) begin
      if (reset) begin
         selOut     <= '0;
         iOut       <= '0;
         qOut       <= '0;
         bestMetric <= '0;
         symEnOut   <= 1'b0;
      end else begin
         symEnOut <= in.valid;  // exactly one cycle per symbol
         if (in.valid) begin
            selOut     <= winIdx;
            iOut       <= in.rotI[winIdx];  // rotated pair of the winner feeds the phase loop
            qOut       <= in.rotQ[winIdx];
            bestMetric <= in.sum[winIdx];
         end
      end
   end

   // positive and the bit below the sign is set, so the next few symbols could overflow
   assign normalizeOut = (bestMetric[ACS_BITS-1 -: 2] == 2'b01);

   // subtract the offset and wrap, the sign bit tells us whether to clamp
   assign normDiff = metric_t'(bestMetric - NORM_OFFSET);

   always_comb begin
      if (!normalizeIn)
         accMetOut = bestMetric;
      else if (normDiff[ACS_BITS-1])
         accMetOut = '0;  // went below zero, floor the metric
      else
         accMetOut = normDiff;
   end

endmodule

/* dv/acsTb.sv */
`timescale 1ns/100ps

module acsTb import acsPkg::*; ();

   localparam int NROWS    = 36;  // 4 directed rows, then a 32-step tilt sweep with random data
   localparam int DIRECTED = 4;
   localparam int OFFS [2][NUM_BRANCHES] = '{'{0, 1, 2, 3}, '{0, 3, 6, 9}};  // 45 set, 54 set

   logic       clk, reset, symEn, symEnEven, normalizeIn;
   tilt_t      tilt;
   mfSample_t  mfI45 [NUM_BRANCHES];
   mfSample_t  mfQ45 [NUM_BRANCHES];
   mfSample_t  mfI54 [NUM_BRANCHES];
   mfSample_t  mfQ54 [NUM_BRANCHES];
   metric_t    accMet45 [NUM_BRANCHES];
   metric_t    accMet54 [NUM_BRANCHES];
   branchIdx_t selOut;
   rotSample_t iOut, qOut;
   metric_t    accMetOut;
   logic       normalizeOut, symEnOut;

   // stimulus columns, the middle index is the set (0 for 45, 1 for 54)
   int mfITbl [NROWS][2][NUM_BRANCHES];
   int mfQTbl [NROWS][2][NUM_BRANCHES];
   int metTbl [NROWS][2][NUM_BRANCHES];
   int evenTbl [NROWS];
   int tiltTbl [NROWS];
   int normInTbl [NROWS];
   int gapTbl [NROWS];  // cycles until the next symEn
   // expected columns, filled by the reference model
   branchIdx_t expIdx [NROWS];
   rotSample_t expI [NROWS];
   rotSample_t expQ [NROWS];
   metric_t    expMet [NROWS];
   logic       expNorm [NROWS];

   int issueCycle [NROWS];  // edge number of each symEn
   int cycleCnt = 0;
   int errors = 0;
   int pulses = 0;
   int checked = 0;
   int seed = 39;

   acsTop i_dut (
      .clk (clk), .reset (reset), .symEn (symEn), .symEnEven (symEnEven), .tilt (tilt),
      .mfI45 (mfI45), .mfQ45 (mfQ45), .mfI54 (mfI54), .mfQ54 (mfQ54),
      .accMet45 (accMet45), .accMet54 (accMet54), .normalizeIn (normalizeIn),
      .selOut (selOut), .iOut (iOut), .qOut (qOut), .accMetOut (accMetOut),
      .normalizeOut (normalizeOut), .symEnOut (symEnOut)
   );

   initial clk = 1'b0;
   always #5 clk = ~clk;

   always @(posedge clk) cycleCnt <= cycleCnt + 1;  // edge counter for the latency check

   task automatic checkSample(input string what, input rotSample_t got, input rotSample_t exp);
      if (got !== exp) begin
         errors++;
         $display("MISMATCH at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
      end
   endtask

   task automatic checkMetric(input string what, input metric_t got, input metric_t exp);
      if (got !== exp) begin
         errors++;
         $display("MISMATCH at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
      end
   endtask

   task automatic checkIdx(input string what, input branchIdx_t got, input branchIdx_t exp);
      if (got !== exp) begin
         errors++;
         $display("MISMATCH at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
      end
   endtask

   task automatic checkFlag(input string what, input logic got, input logic exp);
      if (got !== exp) begin
         errors++;
         $display("MISMATCH at %0t ns: %s is %b, expected %b", $time, what, got, exp);
      end
   endtask

   // two's complement wrap of an integer to the given width
   function automatic int wrapBits(input int v, input int bits);
      int m;
      m = 1 << bits;
      v = v & (m - 1);
      return (v >= m / 2) ? v - m : v;
   endfunction

   // top 8 bits kept within +-100, the two low bits are noise the rotator must ignore
   function automatic int randSample();
      int v;
      v = $random(seed) % 101;
      return v * 4 + ($random(seed) & 3);
   endfunction

   // reference model, rotate each branch of the chosen set and keep the largest sum
   task automatic computeExpected(input int k);
      int s, ang, sn, cs, i8, q8, ri, rq, sum, best, d;
      best = -100000;
      s = evenTbl[k];
      for (int b = 0; b < NUM_BRANCHES; b++) begin
         ang = (96 - (tiltTbl[k] + 2 * OFFS[s][b])) % 32;  // minus tilt plus offset, one turn
         sn  = sineTable[ang];
         cs  = sineTable[(ang + 8) % 32];
         i8  = mfITbl[k][s][b] >>> 2;
         q8  = mfQTbl[k][s][b] >>> 2;
         ri  = wrapBits((i8 * cs - q8 * sn) >>> TRIG_BITS, ROT_BITS);
         rq  = wrapBits((i8 * sn + q8 * cs) >>> TRIG_BITS, ROT_BITS);
         sum = wrapBits(metTbl[k][s][b] + ri, ACS_BITS);
         if (sum > best) begin  // strict, so the lowest index keeps a tie
            best      = sum;
            expIdx[k] = branchIdx_t'(b);
            expI[k]   = rotSample_t'(ri);
            expQ[k]   = rotSample_t'(rq);
         end
      end
      expNorm[k] = (best >= 256);  // top two bits 01
      d = wrapBits(best - NORM_OFFSET, ACS_BITS);
      expMet[k] = metric_t'(normInTbl[k] == 0 ? best : (d < 0 ? 0 : d));
   endtask

   task automatic buildTable();
      int tieMet [NUM_BRANCHES]  = '{50, 200, 200, 10};  // branches 1 and 2 tie
      int highMet [NUM_BRANCHES] = '{300, 100, 290, 0};  // best above 256 raises normalizeOut
      int lowMet [NUM_BRANCHES]  = '{60, 20, 30, 10};    // best below 128 clamps to 0
      for (int k = 0; k < NROWS; k++) begin
         for (int s = 0; s < 2; s++) begin
            for (int b = 0; b < NUM_BRANCHES; b++) begin
               mfITbl[k][s][b] = randSample();
               mfQTbl[k][s][b] = randSample();
               metTbl[k][s][b] = ($random(seed) & 32'h7fffffff) % 450;
            end
         end
         evenTbl[k]   = $random(seed) & 1;
         normInTbl[k] = $random(seed) & 1;
         tiltTbl[k]   = (k - DIRECTED) & 31;  // sweep rows see every tilt once
         gapTbl[k]    = (k < DIRECTED || k % 3 == 0) ? 6 : 4;
      end
      // row 0 has equal metrics and branch 2 dominant, row 1 ties branches 1 and 2
      for (int b = 0; b < NUM_BRANCHES; b++) begin
         mfITbl[0][0][b] = (b == 2) ? 360 : 80;
         mfQTbl[0][0][b] = 0;
         metTbl[0][0][b] = 100;
         mfITbl[1][0][b] = 0;
         mfQTbl[1][0][b] = 0;
         metTbl[1][0][b] = tieMet[b];
         mfITbl[2][1][b] = (b == 0) ? 160 : 0;
         mfQTbl[2][1][b] = 0;
         metTbl[2][0][b] = 500;  // 45 metrics are large but must be ignored on an even symbol
         metTbl[2][1][b] = highMet[b];
         mfITbl[3][0][b] = 0;
         mfQTbl[3][0][b] = 0;
         metTbl[3][0][b] = lowMet[b];
         metTbl[3][1][b] = 480;
      end
      // only row 2 is even and tilted, rows 2 and 3 ask for normalization
      for (int k = 0; k < DIRECTED; k++) begin
         evenTbl[k]   = (k == 2) ? 1 : 0;
         tiltTbl[k]   = (k == 2) ? 5 : 0;
         normInTbl[k] = (k >= 2) ? 1 : 0;
      end
      for (int k = 0; k < NROWS; k++)
         computeExpected(k);
   endtask

   task automatic driveRow(input int k);
      for (int b = 0; b < NUM_BRANCHES; b++) begin
         mfI45[b]    = mfSample_t'(mfITbl[k][0][b]);
         mfQ45[b]    = mfSample_t'(mfQTbl[k][0][b]);
         mfI54[b]    = mfSample_t'(mfITbl[k][1][b]);
         mfQ54[b]    = mfSample_t'(mfQTbl[k][1][b]);
         accMet45[b] = metric_t'(metTbl[k][0][b]);
         accMet54[b] = metric_t'(metTbl[k][1][b]);
      end
      symEnEven = evenTbl[k][0];
      tilt      = tilt_t'(tiltTbl[k]);
      symEn     = 1'b1;
   endtask

   initial begin
      reset = 1'b1;
      symEn = 1'b0;
      symEnEven = 1'b0;
      normalizeIn = 1'b0;
      tilt = '0;
      for (int b = 0; b < NUM_BRANCHES; b++) begin
         mfI45[b] = '0;
         mfQ45[b] = '0;
         mfI54[b] = '0;
         mfQ54[b] = '0;
         accMet45[b] = '0;
         accMet54[b] = '0;
      end
      buildTable();
      repeat (10) @(posedge clk);
      #1 reset = 1'b0;
      @(posedge clk);
      #2;  // outputs sit at their reset values until the first symbol comes out
      checkFlag("idle symEnOut", symEnOut, 1'b0);
      checkFlag("idle normalizeOut", normalizeOut, 1'b0);
      checkIdx("idle selOut", selOut, '0);
      checkSample("idle iOut", iOut, '0);
      checkSample("idle qOut", qOut, '0);
      checkMetric("idle accMetOut", accMetOut, '0);
      @(posedge clk);
      #1;
      for (int k = 0; k < NROWS; k++) begin
         driveRow(k);
         issueCycle[k] = cycleCnt + 1;  // the coming edge samples symEn
         repeat (gapTbl[k]) begin
            @(posedge clk);
            #1 symEn = 1'b0;
         end
      end
      wait (checked == NROWS);
      repeat (8) @(posedge clk);  // room for any stray pulse
      $display("errors %0d, symEnOut pulses %0d of %0d", errors, pulses, NROWS);
      if (errors == 0 && pulses == NROWS) begin
         $display("*** TEST PASSED ***");
      end else begin
         $display("*** TEST FAILED ***");
      end
      $finish;
   end

   // checker, takes each symEnOut against the next row in order
   initial begin
      forever begin
         @(posedge clk);
         #2;
         if (!reset && symEnOut === 1'b1) begin
            pulses++;
            if (checked >= NROWS) begin
               errors++;
               $display("symEnOut pulsed at %0t ns with no symbol left to answer", $time);
            end else begin
               normalizeIn = normInTbl[checked][0];  // accMetOut follows it without a clock
               #1;
               if (cycleCnt - issueCycle[checked] != 6) begin
                  errors++;
                  $display("row %0d came out %0d edges after its symEn instead of 6",
                           checked, cycleCnt - issueCycle[checked]);
               end
               checkIdx("selOut", selOut, expIdx[checked]);
               checkSample("iOut", iOut, expI[checked]);
               checkSample("qOut", qOut, expQ[checked]);
               checkMetric("accMetOut", accMetOut, expMet[checked]);
               checkFlag("normalizeOut", normalizeOut, expNorm[checked]);
               checked++;
            end
         end
      end
   end

   // watchdog sized from the table, each row takes at most six cycles
   initial begin
      repeat (NROWS * 6 + 40) @(posedge clk);
      $display("timeout, only %0d of %0d symbols came out", checked, NROWS);
      $display("*** TEST FAILED ***");
      $finish;
   end

endmodule

/* src.f */
design/acsPkg.sv
design/rotBranchIf.sv
design/branchMetricIf.sv
design/branchRotator.sv
design/metricAdder.sv
design/survivorSelect.sv
design/acsTop.sv
dv/acsTb.sv
